// File: mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int SEG_W  = 3;

    // Top address bits of the uncached window
    localparam logic [SEG_W-1:0] UNCACHED_SEG = 3'b101;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic {
        ROUTE_CACHED,
        ROUTE_UNCACHED
    } route_e;

    typedef enum logic {
        OWNER_CACHE,
        OWNER_SB
    } bus_owner_e;

    typedef enum logic [1:0] {
        CACHE_IDLE,
        CACHE_RESP,
        CACHE_REFILL,
        CACHE_WRITE
    } cache_state_e;

    typedef enum logic [1:0] {
        SB_IDLE,
        SB_DRAIN,
        SB_READ
    } sb_state_e;

endpackage

// File: mem_if.sv
// CPU-style port, request with addr_ok then in-order data_ok
interface mem_req_if;
    import mem_pkg::*;

    logic  req;
    logic  wr;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    data_t rdata;
    logic  addr_ok;
    logic  data_ok;

    modport requester (
        output req, wr, addr, wdata, wstrb,
        input  rdata, addr_ok, data_ok
    );

    modport responder (
        input  req, wr, addr, wdata, wstrb,
        output rdata, addr_ok, data_ok
    );
endinterface

// Memory bus, one-cycle strobe and a later one-cycle ack
interface mem_bus_if;
    import mem_pkg::*;

    logic  bus_req;
    logic  bus_wr;
    addr_t bus_addr;
    data_t bus_wdata;
    strb_t bus_wstrb;
    logic  bus_ack;
    data_t bus_rdata;

    modport initiator (
        output bus_req, bus_wr, bus_addr, bus_wdata, bus_wstrb,
        input  bus_ack, bus_rdata
    );

    modport target (
        input  bus_req, bus_wr, bus_addr, bus_wdata, bus_wstrb,
        output bus_ack, bus_rdata
    );
endinterface

// File: route_tracker.sv
module route_tracker #(
    parameter int TRACK_DEPTH = 8
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           data_req,
    input  logic           data_wr,
    input  mem_pkg::addr_t data_addr,
    input  mem_pkg::data_t data_wdata,
    input  mem_pkg::strb_t data_wstrb,
    output mem_pkg::data_t data_rdata,
    output logic           data_addr_ok,
    output logic           data_data_ok,
    mem_req_if.requester   cached_port,
    mem_req_if.requester   uncached_port
);
    import mem_pkg::*;

    localparam int PTR_W = $clog2(TRACK_DEPTH);
    localparam int CNT_W = $clog2(TRACK_DEPTH + 1);

    route_e           route_fifo [TRACK_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    route_e           req_route;
    route_e           head_route;
    addr_t            redi_addr;
    logic             full;
    logic             empty;
    logic             stall;
    logic             path_addr_ok;
    logic             push;
    logic             pop;

    assign req_route = (data_addr[ADDR_W-1 -: SEG_W] == UNCACHED_SEG) ?
                       ROUTE_UNCACHED : ROUTE_CACHED;
    // Simple MMU
    assign redi_addr = {{SEG_W{1'b0}}, data_addr[ADDR_W-SEG_W-1:0]};

    assign head_route = route_fifo[rd_ptr];
    assign full       = (count == CNT_W'(TRACK_DEPTH));
    assign empty      = (count == '0);
    // Outstanding requests all share one route
    assign stall      = full || (!empty && (head_route != req_route));

    assign path_addr_ok = (req_route == ROUTE_UNCACHED) ? uncached_port.addr_ok :
                                                          cached_port.addr_ok;
    assign data_addr_ok = path_addr_ok && !stall;
    assign data_data_ok = cached_port.data_ok || uncached_port.data_ok;
    assign data_rdata   = (head_route == ROUTE_UNCACHED) ? uncached_port.rdata :
                                                           cached_port.rdata;

    assign push = data_req && data_addr_ok;
    assign pop  = data_data_ok;

    assign cached_port.req     = data_req && !stall && (req_route == ROUTE_CACHED);
    assign cached_port.wr      = data_wr;
    assign cached_port.addr    = redi_addr;
    assign cached_port.wdata   = data_wdata;
    assign cached_port.wstrb   = data_wstrb;

    assign uncached_port.req   = data_req && !stall && (req_route == ROUTE_UNCACHED);
    assign uncached_port.wr    = data_wr;
    assign uncached_port.addr  = redi_addr;
    assign uncached_port.wdata = data_wdata;
    assign uncached_port.wstrb = data_wstrb;

    ////////////////////////////////////////////////////////////////////////////
    // Route FIFO

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(TRACK_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(TRACK_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            route_fifo[wr_ptr] <= req_route;
        end
    end

    // Only one path is ever answering
    a_one_path_resp: assert property (@(posedge aclk) disable iff (!aresetn)
        !(cached_port.data_ok && uncached_port.data_ok));

    // A path never answers a request the tracker did not accept
    a_no_resp_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        data_data_ok |-> !empty);

endmodule

// File: word_cache.sv
module word_cache #(
    parameter int CACHE_LINES = 8
) (
    input  logic          aclk,
    input  logic          aresetn,
    mem_req_if.responder  cpu_port,
    mem_bus_if.initiator  bus_port
);
    import mem_pkg::*;

    localparam int OFF_W = $clog2(STRB_W);
    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = ADDR_W - OFF_W - IDX_W;

    cache_state_e     state;
    logic             line_valid [CACHE_LINES];
    logic [TAG_W-1:0] line_tag   [CACHE_LINES];
    data_t            line_data  [CACHE_LINES];

    addr_t            req_addr;
    logic             req_wr;
    data_t            req_wdata;
    strb_t            req_wstrb;
    data_t            resp_data;
    logic             bus_req_q;

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] req_idx;
    logic             hit;
    logic             accept;
    logic             refill_done;

    assign idx     = cpu_port.addr[OFF_W +: IDX_W];
    assign req_idx = req_addr[OFF_W +: IDX_W];
    assign hit     = line_valid[idx] && (line_tag[idx] == cpu_port.addr[ADDR_W-1 -: TAG_W]);

    // Accepting again in RESP keeps back-to-back hits at one per cycle
    assign cpu_port.addr_ok = (state == CACHE_IDLE) || (state == CACHE_RESP);
    assign cpu_port.data_ok = (state == CACHE_RESP);
    assign cpu_port.rdata   = resp_data;
    assign accept           = cpu_port.req && cpu_port.addr_ok;
    assign refill_done      = (state == CACHE_REFILL) && bus_port.bus_ack;

    assign bus_port.bus_req   = bus_req_q;
    assign bus_port.bus_wr    = req_wr;
    assign bus_port.bus_addr  = req_addr;
    assign bus_port.bus_wdata = req_wdata;
    assign bus_port.bus_wstrb = req_wstrb;

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= CACHE_IDLE;
            bus_req_q <= 1'b0;
        end else begin
            // Misses and all writes go out on the bus
            bus_req_q <= accept && (cpu_port.wr || !hit);
            case (state)
                CACHE_IDLE, CACHE_RESP: begin
                    if (!accept) begin
                        state <= CACHE_IDLE;
                    end else if (cpu_port.wr) begin
                        state <= CACHE_WRITE;
                    end else if (hit) begin
                        state <= CACHE_RESP;
                    end else begin
                        state <= CACHE_REFILL;
                    end
                end
                CACHE_REFILL, CACHE_WRITE: begin
                    if (bus_port.bus_ack) begin
                        state <= CACHE_RESP;
                    end
                end
                default: state <= CACHE_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < CACHE_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (refill_done) begin
            line_valid[req_idx] <= 1'b1;
        end
    end

    // Refill fills the entry, a write hit merges bytes, a write miss leaves it
    always_ff @(posedge aclk) begin
        if (refill_done) begin
            line_tag[req_idx]  <= req_addr[ADDR_W-1 -: TAG_W];
            line_data[req_idx] <= bus_port.bus_rdata;
        end else if (accept && cpu_port.wr && hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (cpu_port.wstrb[b]) begin
                    line_data[idx][8*b +: 8] <= cpu_port.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_addr  <= cpu_port.addr;
            req_wr    <= cpu_port.wr;
            req_wdata <= cpu_port.wdata;
            req_wstrb <= cpu_port.wstrb;
            resp_data <= line_data[idx];
        end else if (refill_done) begin
            resp_data <= bus_port.bus_rdata;
        end
    end

    // Read acks routed back by the arbiter land only on a waiting refill
    a_refill_on_ack: assert property (@(posedge aclk) disable iff (!aresetn)
        (bus_port.bus_ack && !req_wr) |-> (state == CACHE_REFILL));

endmodule

// File: store_buffer.sv
module store_buffer #(
    parameter int SB_DEPTH = 4
) (
    input  logic          aclk,
    input  logic          aresetn,
    mem_req_if.responder  cpu_port,
    mem_bus_if.initiator  bus_port
);
    import mem_pkg::*;

    localparam int PTR_W = $clog2(SB_DEPTH);
    localparam int CNT_W = $clog2(SB_DEPTH + 1);

    addr_t            q_addr [SB_DEPTH];
    data_t            q_data [SB_DEPTH];
    strb_t            q_strb [SB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    sb_state_e        state;
    logic             bus_req_q;
    logic             bus_wr_q;
    addr_t            bus_addr_q;
    data_t            bus_wdata_q;
    strb_t            bus_wstrb_q;
    data_t            rd_data_q;
    logic             wr_ok_q;
    logic             rd_ok_q;

    logic             full;
    logic             empty;
    logic             accept;
    logic             push;
    logic             pop;
    logic             read_accept;
    logic             drain_start;

    assign full  = (count == CNT_W'(SB_DEPTH));
    assign empty = (count == '0);

    // Nothing is taken while a read waits, so answers stay in order
    assign cpu_port.addr_ok = (state != SB_READ) && (cpu_port.wr ? !full : empty);
    assign cpu_port.data_ok = wr_ok_q || rd_ok_q;
    assign cpu_port.rdata   = rd_data_q;

    assign accept      = cpu_port.req && cpu_port.addr_ok;
    assign push        = accept && cpu_port.wr;
    assign read_accept = accept && !cpu_port.wr;
    assign drain_start = (state == SB_IDLE) && !empty;
    assign pop         = (state == SB_DRAIN) && bus_port.bus_ack;

    assign bus_port.bus_req   = bus_req_q;
    assign bus_port.bus_wr    = bus_wr_q;
    assign bus_port.bus_addr  = bus_addr_q;
    assign bus_port.bus_wdata = bus_wdata_q;
    assign bus_port.bus_wstrb = bus_wstrb_q;

    ////////////////////////////////////////////////////////////////////////////
    // Queue pointers and bus sequencing

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            state     <= SB_IDLE;
            bus_req_q <= 1'b0;
            wr_ok_q   <= 1'b0;
            rd_ok_q   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(SB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(SB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + CNT_W'(push) - CNT_W'(pop);
            bus_req_q <= drain_start || read_accept;
            wr_ok_q   <= push;
            rd_ok_q   <= (state == SB_READ) && bus_port.bus_ack;
            case (state)
                SB_IDLE: begin
                    if (read_accept) begin
                        state <= SB_READ;
                    end else if (drain_start) begin
                        state <= SB_DRAIN;
                    end
                end
                SB_DRAIN, SB_READ: begin
                    if (bus_port.bus_ack) begin
                        state <= SB_IDLE;
                    end
                end
                default: state <= SB_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            q_addr[wr_ptr] <= cpu_port.addr;
            q_data[wr_ptr] <= cpu_port.wdata;
            q_strb[wr_ptr] <= cpu_port.wstrb;
        end
        if (drain_start) begin
            bus_wr_q    <= 1'b1;
            bus_addr_q  <= q_addr[rd_ptr];
            bus_wdata_q <= q_data[rd_ptr];
            bus_wstrb_q <= q_strb[rd_ptr];
        end else if (read_accept) begin
            bus_wr_q    <= 1'b0;
            bus_addr_q  <= cpu_port.addr;
            bus_wstrb_q <= '0;
        end
        if ((state == SB_READ) && bus_port.bus_ack) begin
            rd_data_q <= bus_port.bus_rdata;
        end
    end

    // A drain ack always retires a queued write
    a_pop_not_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        pop |-> !empty);

endmodule

// File: bus_arbiter.sv
module bus_arbiter (
    input  logic          aclk,
    input  logic          aresetn,
    mem_bus_if.target     cache_bus,
    mem_bus_if.target     sb_bus,
    mem_bus_if.initiator  mem_bus
);
    import mem_pkg::*;

    logic       busy;
    bus_owner_e owner;
    logic       cache_wait;
    logic       sb_wait;
    logic       cache_pend;
    logic       sb_pend;
    logic       grant_cache;
    logic       grant_sb;

    assign cache_pend = cache_bus.bus_req || cache_wait;
    assign sb_pend    = sb_bus.bus_req || sb_wait;

    // Round robin, the last owner yields on a tie
    assign grant_cache = !busy && cache_pend && (!sb_pend || (owner == OWNER_SB));
    assign grant_sb    = !busy && sb_pend && !grant_cache;

    // Peer fields stay stable until their ack, so a grant may forward late
    assign mem_bus.bus_req   = grant_cache || grant_sb;
    assign mem_bus.bus_wr    = grant_sb ? sb_bus.bus_wr    : cache_bus.bus_wr;
    assign mem_bus.bus_addr  = grant_sb ? sb_bus.bus_addr  : cache_bus.bus_addr;
    assign mem_bus.bus_wdata = grant_sb ? sb_bus.bus_wdata : cache_bus.bus_wdata;
    assign mem_bus.bus_wstrb = grant_sb ? sb_bus.bus_wstrb : cache_bus.bus_wstrb;

    assign cache_bus.bus_ack   = mem_bus.bus_ack && busy && (owner == OWNER_CACHE);
    assign cache_bus.bus_rdata = mem_bus.bus_rdata;
    assign sb_bus.bus_ack      = mem_bus.bus_ack && busy && (owner == OWNER_SB);
    assign sb_bus.bus_rdata    = mem_bus.bus_rdata;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy       <= 1'b0;
            owner      <= OWNER_SB;
            cache_wait <= 1'b0;
            sb_wait    <= 1'b0;
        end else begin
            cache_wait <= cache_pend && !grant_cache;
            sb_wait    <= sb_pend && !grant_sb;
            if (grant_cache || grant_sb) begin
                busy  <= 1'b1;
                owner <= grant_sb ? OWNER_SB : OWNER_CACHE;
            end else if (mem_bus.bus_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // An ack only ever closes an open transaction
    a_ack_when_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_bus.bus_ack |-> busy);

    // Each peer keeps one transaction outstanding at most
    a_one_per_cache: assert property (@(posedge aclk) disable iff (!aresetn)
        cache_wait |-> !cache_bus.bus_req);

    a_one_per_sb: assert property (@(posedge aclk) disable iff (!aresetn)
        sb_wait |-> !sb_bus.bus_req);

endmodule

// File: mem_router_top.sv
module mem_router_top #(
    parameter int TRACK_DEPTH = 8,
    parameter int CACHE_LINES = 8,
    parameter int SB_DEPTH    = 4
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           data_req,
    input  logic           data_wr,
    input  mem_pkg::addr_t data_addr,
    input  mem_pkg::data_t data_wdata,
    input  mem_pkg::strb_t data_wstrb,
    output mem_pkg::data_t data_rdata,
    output logic           data_addr_ok,
    output logic           data_data_ok,
    output logic           bus_req,
    output logic           bus_wr,
    output mem_pkg::addr_t bus_addr,
    output mem_pkg::data_t bus_wdata,
    output mem_pkg::strb_t bus_wstrb,
    input  logic           bus_ack,
    input  mem_pkg::data_t bus_rdata
);

    mem_req_if cache_req ();
    mem_req_if sb_req ();
    mem_bus_if cache_bus ();
    mem_bus_if sb_bus ();
    mem_bus_if ext_bus ();

    route_tracker #(
        .TRACK_DEPTH (TRACK_DEPTH)
    ) route_tracker_inst (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .data_req      (data_req),
        .data_wr       (data_wr),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_wstrb    (data_wstrb),
        .data_rdata    (data_rdata),
        .data_addr_ok  (data_addr_ok),
        .data_data_ok  (data_data_ok),
        .cached_port   (cache_req),
        .uncached_port (sb_req)
    );

    word_cache #(
        .CACHE_LINES (CACHE_LINES)
    ) word_cache_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .cpu_port (cache_req),
        .bus_port (cache_bus)
    );

    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) store_buffer_inst (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .cpu_port (sb_req),
        .bus_port (sb_bus)
    );

    bus_arbiter bus_arbiter_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .cache_bus (cache_bus),
        .sb_bus    (sb_bus),
        .mem_bus   (ext_bus)
    );

    // External memory bus
    assign bus_req           = ext_bus.bus_req;
    assign bus_wr            = ext_bus.bus_wr;
    assign bus_addr          = ext_bus.bus_addr;
    assign bus_wdata         = ext_bus.bus_wdata;
    assign bus_wstrb         = ext_bus.bus_wstrb;
    assign ext_bus.bus_ack   = bus_ack;
    assign ext_bus.bus_rdata = bus_rdata;

endmodule

// File: tb_bus_memory.sv
module tb_bus_memory #(
    parameter integer SEED = 1
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           bus_req,
    input  logic           bus_wr,
    input  mem_pkg::addr_t bus_addr,
    input  mem_pkg::data_t bus_wdata,
    input  mem_pkg::strb_t bus_wstrb,
    output logic           bus_ack,
    output mem_pkg::data_t bus_rdata
);
    import mem_pkg::*;

    integer seed     = SEED;
    data_t  mem [addr_t];
    logic   ack_q    = 1'b0;
    data_t  rdata_q  = '0;
    logic   pending  = 1'b0;
    int     delay    = 0;
    logic   op_wr    = 1'b0;
    addr_t  op_addr  = '0;
    data_t  op_wdata = '0;
    strb_t  op_wstrb = '0;

    assign bus_ack   = ack_q;
    assign bus_rdata = rdata_q;

    // Words never written read back a pattern of their own address
    function automatic data_t fill_word(addr_t wa);
        return {wa[15:0], wa[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic data_t load_word(addr_t wa);
        return mem.exists(wa) ? mem[wa] : fill_word(wa);
    endfunction

    always @(posedge aclk) begin : model
        data_t word;
        if (!aresetn) begin
            ack_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (pending) begin
                if (delay == 0) begin
                    ack_q   <= 1'b1;
                    pending <= 1'b0;
                    if (op_wr) begin
                        word = load_word(op_addr);
                        for (int b = 0; b < STRB_W; b++) begin
                            if (op_wstrb[b]) begin
                                word[8*b +: 8] = op_wdata[8*b +: 8];
                            end
                        end
                        mem[op_addr] = word;
                    end else begin
                        rdata_q <= load_word(op_addr);
                    end
                end else begin
                    delay <= delay - 1;
                end
            end else if (bus_req) begin
                // Ack comes 1 to 6 cycles after the strobe
                pending  <= 1'b1;
                op_wr    <= bus_wr;
                op_addr  <= {bus_addr[ADDR_W-1:2], 2'b00};
                op_wdata <= bus_wdata;
                op_wstrb <= bus_wstrb;
                delay    <= {$random(seed)} % 6;
            end
        end
    end

endmodule

// File: tb_mem_router.sv
module tb_mem_router;
    import mem_pkg::*;

    localparam integer     SEED      = 32'h1cf0;
    localparam int         TIMEOUT   = 200;
    localparam int         RAND_OPS  = 300;
    localparam logic [2:0] UC_SEG    = 3'b101;
    localparam addr_t      PHYS_MASK = 32'h1fff_ffff;
    localparam addr_t      C_BASE    = 32'h8001_0000;
    localparam addr_t      UC_BASE   = 32'ha002_0000;
    localparam addr_t      UC_PHYS   = 32'h0002_0000;

    typedef struct packed {
        logic  rd;
        addr_t addr;
        data_t data;
    } expect_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } bus_wr_t;

    logic  aclk;
    logic  aresetn;
    logic  data_req;
    logic  data_wr;
    addr_t data_addr;
    data_t data_wdata;
    strb_t data_wstrb;
    data_t data_rdata;
    logic  data_addr_ok;
    logic  data_data_ok;
    logic  bus_req;
    logic  bus_wr;
    addr_t bus_addr;
    data_t bus_wdata;
    strb_t bus_wstrb;
    logic  bus_ack;
    data_t bus_rdata;

    integer  seed;
    string   phase        = "reset";
    logic    expect_hit   = 1'b0;
    logic    reset_seen   = 1'b0;
    logic    bus_open     = 1'b0;
    logic    aborted      = 1'b0;
    int      data_errors  = 0;
    int      proto_errors = 0;
    int      timeouts     = 0;
    int      accepted     = 0;
    int      responses    = 0;
    data_t   shadow [addr_t];
    expect_t resp_q [$];
    bus_wr_t cwr_q [$];
    bus_wr_t uwr_q [$];

    mem_router_top mem_router_top_inst (.*);

    tb_bus_memory #(
        .SEED (SEED)
    ) bus_memory_inst (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic data_t fill_word(addr_t wa);
        return {wa[15:0], wa[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic data_t shadow_word(addr_t wa);
        return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
    endfunction

    function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic void check_bus_write(string name, bus_wr_t w);
        assert (bus_addr == w.addr) else begin
            data_errors++;
            $display("[FAIL] %s addr expected %h actual %h", name, w.addr, bus_addr);
        end
        assert ({bus_wstrb, bus_wdata} == {w.strb, w.data}) else begin
            data_errors++;
            $display("[FAIL] %s strb/data expected %h actual %h", name,
                     {w.strb, w.data}, {bus_wstrb, bus_wdata});
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Monitors and scoreboard

    always @(posedge aclk) begin : monitor
        expect_t e;
        bus_wr_t w;
        addr_t   pa;
        reset_seen <= reset_seen || !aresetn;
        if (!aresetn) begin
            bus_open <= 1'b0;
        end else if (bus_req) begin
            bus_open <= 1'b1;
        end else if (bus_ack) begin
            bus_open <= 1'b0;
        end
        if (aresetn && data_data_ok) begin
            responses++;
            if (resp_q.size() == 0) begin
                proto_errors++;
                $display("Response arrived with no request outstanding");
            end else begin
                e = resp_q.pop_front();
                if (e.rd) begin
                    assert (data_rdata == e.data) else begin
                        data_errors++;
                        $display("[FAIL] %s read %h expected %h actual %h",
                                 phase, e.addr, e.data, data_rdata);
                    end
                end
            end
        end
        if (aresetn && data_req && data_addr_ok) begin
            accepted++;
            pa     = data_addr & PHYS_MASK;
            e.rd   = !data_wr;
            e.addr = data_addr;
            e.data = shadow_word(pa);
            if (data_wr) begin
                shadow[pa] = merge_bytes(shadow_word(pa), data_wdata, data_wstrb);
                w.addr = pa;
                w.data = data_wdata;
                w.strb = data_wstrb;
                if (data_addr[31:29] == UC_SEG) begin
                    uwr_q.push_back(w);
                end else begin
                    cwr_q.push_back(w);
                end
            end
            resp_q.push_back(e);
        end
        // Each path puts its writes on the bus in program order
        if (aresetn && bus_req && bus_wr) begin
            if ((bus_addr & 32'hffff_0000) == UC_PHYS) begin
                if (uwr_q.size() == 0) begin
                    proto_errors++;
                    $display("Uncached bus write to %h with no write pending", bus_addr);
                end else begin
                    check_bus_write("uncached_bus_order", uwr_q.pop_front());
                end
            end else if (cwr_q.size() == 0) begin
                proto_errors++;
                $display("Cached bus write to %h with no write pending", bus_addr);
            end else begin
                check_bus_write("cached_bus_order", cwr_q.pop_front());
            end
        end
    end

    a_reset_quiet: assert property (@(posedge aclk)
        (!aresetn && reset_seen) |-> (!data_data_ok && !bus_req))
        else begin
            proto_errors++;
            $display("data_ok or bus_req went high during reset");
        end

    a_reset_exit: assert property (@(posedge aclk)
        $rose(aresetn) |-> (!data_data_ok && !bus_req))
        else begin
            proto_errors++;
            $display("data_ok or bus_req high right after reset");
        end

    a_hit_latency: assert property (@(posedge aclk) disable iff (!aresetn)
        (data_req && data_addr_ok && expect_hit) |=> (data_data_ok && !bus_req))
        else begin
            proto_errors++;
            $display("Cached read hit did not answer one cycle after acceptance without bus");
        end

    a_uc_write_latency: assert property (@(posedge aclk) disable iff (!aresetn)
        (data_req && data_addr_ok && data_wr && (data_addr[31:29] == UC_SEG)) |=> data_data_ok)
        else begin
            proto_errors++;
            $display("Uncached write did not answer one cycle after acceptance");
        end

    a_bus_single: assert property (@(posedge aclk) disable iff (!aresetn)
        bus_req |-> !bus_open)
        else begin
            proto_errors++;
            $display("Second bus request issued before the previous ack");
        end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Called right after a rising edge, returns on the accepting edge
    task automatic issue(input logic wr, input addr_t addr, input data_t wdata,
                         input strb_t strb, input logic hit_chk);
        int waited;
        waited = 0;
        if (aborted) begin
            return;
        end
        data_req   <= 1'b1;
        data_wr    <= wr;
        data_addr  <= addr;
        data_wdata <= wdata;
        data_wstrb <= strb;
        expect_hit <= hit_chk;
        @(posedge aclk);
        while (!data_addr_ok && !aborted) begin
            waited++;
            if (waited > TIMEOUT) begin
                aborted = 1'b1;
                timeouts++;
                $display("Timeout: request to %h not accepted in %0d cycles", addr, TIMEOUT);
            end else begin
                @(posedge aclk);
            end
        end
        data_req   <= 1'b0;
        expect_hit <= 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge aclk);
        while (!aborted && (resp_q.size() != 0 || cwr_q.size() != 0 || uwr_q.size() != 0)) begin
            waited++;
            if (waited > TIMEOUT) begin
                aborted = 1'b1;
                timeouts++;
                $display("Timeout: outstanding requests did not complete in %s", phase);
            end else begin
                @(negedge aclk);
            end
        end
        @(posedge aclk);
    endtask

    task automatic random_op();
        logic [31:0] r;
        addr_t       addr;
        r    = $random(seed);
        // 16 words per range, twice the cache size, so entries get replaced
        addr = (r[0] ? UC_BASE : C_BASE) + {26'd0, r[4:1], 2'b00};
        issue(r[5], addr, $random(seed), r[9:6], 1'b0);
        repeat (r[11:10]) @(posedge aclk);
    endtask

    initial begin
        seed       = SEED;
        aresetn    = 1'b0;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_wstrb = '0;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);

        phase = "cached_rw";
        issue(1'b1, C_BASE + 32'h20, 32'hdead_beef, 4'b0101, 1'b0);
        issue(1'b0, C_BASE + 32'h20, '0, '0, 1'b0);
        wait_idle();
        issue(1'b0, C_BASE + 32'h20, '0, '0, 1'b1);
        wait_idle();

        phase = "uncached_wr";
        for (int i = 0; i < 6; i++) begin
            issue(1'b1, UC_BASE + 32'(i * 4), 32'h1000_0000 + 32'(i), 4'hf, 1'b0);
        end
        wait_idle();

        phase = "uncached_rd";
        issue(1'b1, UC_BASE + 32'h40, 32'h1111_2222, 4'hf, 1'b0);
        issue(1'b1, UC_BASE + 32'h40, 32'haabb_ccdd, 4'b1100, 1'b0);
        issue(1'b0, UC_BASE + 32'h40, '0, '0, 1'b0);
        wait_idle();

        phase = "random";
        repeat (RAND_OPS) random_op();
        wait_idle();

        @(negedge aclk);
        assert (accepted == responses) else begin
            data_errors++;
            $display("[FAIL] response_count expected %0d actual %0d", accepted, responses);
        end
        $display("Errors: %0d data, %0d protocol, %0d timeout (%0d requests, %0d responses)",
                 data_errors, proto_errors, timeouts, accepted, responses);
        if (data_errors + proto_errors + timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
mem_pkg.sv
mem_if.sv
route_tracker.sv
word_cache.sv
store_buffer.sv
bus_arbiter.sv
mem_router_top.sv
tb_bus_memory.sv
tb_mem_router.sv

// File: Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
TOP       ?= tb_mem_router
RTL_TOP   ?= mem_router_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
